// ==== logic/dma_defs.svh ====
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// bus and datapath widths
`define DMA_ADDR_BITS 32
`define DMA_DATA_BITS 32
`define DMA_LEN_BITS 8
`define DMA_QTY_BITS 16

// longest burst the engine issues
`define DMA_MAX_BEATS 16

// read-to-write buffer entries
`define DMA_FIFO_DEPTH 4

// CPU register map, byte offsets
`define DMA_REG_SRC 4'h0
`define DMA_REG_DST 4'h4
`define DMA_REG_QTY 4'h8
`define DMA_REG_CTRL 4'hC

`endif

// ==== logic/dma_pkg.sv ====
package dma_pkg;

    // burst engine FSM
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        CHECK  = 3'd1,
        AR_REQ = 3'd2,
        AW_REQ = 3'd3,
        STREAM = 3'd4,
        RESP   = 3'd5
    } dma_state_e;

    // CPU register offsets
    // CTRL bit 0 starts a transfer, bit 1 clears status
    typedef enum logic [3:0] {
        REG_SRC  = 4'h0,
        REG_DST  = 4'h4,
        REG_QTY  = 4'h8,
        REG_CTRL = 4'hC
    } dma_reg_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

// ==== logic/dma_cfg_if.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

// transfer setup from the register block to the burst engine
interface dma_cfg_if;

    // one-cycle kick
    logic                      start;

    // held from start until the next CPU register write
    logic [`DMA_ADDR_BITS-1:0] src_addr;
    logic [`DMA_ADDR_BITS-1:0] dst_addr;

    // total words to move
    logic [`DMA_QTY_BITS-1:0]  qty;

    modport decode (
        output start,
        output src_addr,
        output dst_addr,
        output qty
    );

    // values are sampled on the start pulse
    modport engine (
        input start,
        input src_addr,
        input dst_addr,
        input qty
    );

endinterface

// ==== logic/dma_reg_decode.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_reg_decode import dma_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reg_we_i,
    input  logic [3:0]                reg_addr_i,
    input  logic [`DMA_DATA_BITS-1:0] reg_wdata_i,
    dma_cfg_if.decode                 cfg,
    output logic                      clr_o
);
    logic [`DMA_ADDR_BITS-1:0] src_q;
    logic [`DMA_ADDR_BITS-1:0] dst_q;
    logic [`DMA_QTY_BITS-1:0]  qty_q;
    logic                      start_q;
    logic                      clr_q;
    logic                      ctrl_we;

    assign ctrl_we = reg_we_i && (dma_reg_e'(reg_addr_i) == REG_CTRL);

    // configuration words
    always_ff @(posedge clk) begin
        if (reg_we_i) begin
            unique case (dma_reg_e'(reg_addr_i))
                REG_SRC: src_q <= reg_wdata_i[`DMA_ADDR_BITS-1:0];
                REG_DST: dst_q <= reg_wdata_i[`DMA_ADDR_BITS-1:0];
                REG_QTY: qty_q <= reg_wdata_i[`DMA_QTY_BITS-1:0];
                default: ;
            endcase
        end
    end

    // clear wins over start on a ctrl write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q <= 1'b0;
            clr_q   <= 1'b0;
        end else begin
            start_q <= ctrl_we && reg_wdata_i[0] && !reg_wdata_i[1];
            clr_q   <= ctrl_we && reg_wdata_i[1];
        end
    end

    assign cfg.start    = start_q;
    assign cfg.src_addr = src_q;
    assign cfg.dst_addr = dst_q;
    assign cfg.qty      = qty_q;
    assign clr_o        = clr_q;

    a_start_clr_excl: assert property (@(posedge clk) disable iff (rst)
        !(cfg.start && clr_o));

endmodule

// ==== logic/dma_fifo.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wen_i,
    input  logic                      ren_i,
    input  logic [`DMA_DATA_BITS-1:0] data_i,
    output logic [`DMA_DATA_BITS-1:0] data_o,
    output logic                      empty_o,
    output logic                      full_o
);
    localparam int unsigned DEPTH  = `DMA_FIFO_DEPTH;
    localparam int unsigned PTR_W  = $clog2(DEPTH);

    logic [`DMA_DATA_BITS-1:0] mem [DEPTH];
    logic [PTR_W-1:0]          wptr_q;
    logic [PTR_W-1:0]          rptr_q;
    logic [PTR_W:0]            cnt_q;

    always_ff @(posedge clk) begin
        if (wen_i) begin
            mem[wptr_q] <= data_i;
        end
    end

    // pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr_q <= '0;
            rptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (wen_i)
                wptr_q <= wptr_q + 1'b1;
            if (ren_i)
                rptr_q <= rptr_q + 1'b1;
            cnt_q <= cnt_q + (PTR_W+1)'(wen_i) - (PTR_W+1)'(ren_i);
        end
    end

    // head word
    assign data_o  = mem[rptr_q];
    assign empty_o = (cnt_q == '0);
    assign full_o  = (cnt_q == (PTR_W+1)'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        full_o |-> !wen_i);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        empty_o |-> !ren_i);

endmodule

// ==== logic/dma_burst_engine.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_burst_engine import dma_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    dma_cfg_if.engine                 cfg,
    output logic                      busy_o,
    output logic                      done_o,
    output logic                      bad_resp_o,
    output logic [`DMA_ADDR_BITS-1:0] araddr_o,
    output logic [`DMA_LEN_BITS-1:0]  arlen_o,
    output logic                      arvalid_o,
    input  logic                      arready_i,
    input  logic [`DMA_DATA_BITS-1:0] rdata_i,
    input  logic                      rlast_i,
    input  logic                      rvalid_i,
    output logic                      rready_o,
    output logic [`DMA_ADDR_BITS-1:0] awaddr_o,
    output logic [`DMA_LEN_BITS-1:0]  awlen_o,
    output logic                      awvalid_o,
    input  logic                      awready_i,
    output logic [`DMA_DATA_BITS-1:0] wdata_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  logic                      wready_i,
    input  logic [1:0]                bresp_i,
    input  logic                      bvalid_i,
    output logic                      bready_o
);
    localparam logic [`DMA_QTY_BITS-1:0] MAX_BEATS = `DMA_QTY_BITS'(`DMA_MAX_BEATS);

    dma_state_e                state_q;
    dma_state_e                state_d;
    logic [`DMA_QTY_BITS-1:0]  rem_q;
    logic [`DMA_QTY_BITS-1:0]  beats_q;
    logic [`DMA_LEN_BITS-1:0]  len;
    logic [`DMA_LEN_BITS-1:0]  wcnt_q;
    logic [`DMA_ADDR_BITS-1:0] src_q;
    logic [`DMA_ADDR_BITS-1:0] dst_q;
    logic [`DMA_ADDR_BITS-1:0] step;
    logic                      rd_done_q;
    logic                      done_q;
    logic                      ar_hs;
    logic                      aw_hs;
    logic                      r_hs;
    logic                      w_hs;
    logic                      b_hs;
    logic                      fifo_empty;
    logic                      fifo_full;

    assign ar_hs = arvalid_o && arready_i;
    assign aw_hs = awvalid_o && awready_i;
    assign r_hs  = rvalid_i && rready_o;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bvalid_i && bready_o;

    // AXI length is beats minus one
    assign len  = `DMA_LEN_BITS'(beats_q - 1'b1);
    assign step = `DMA_ADDR_BITS'({beats_q, 2'b00});

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (cfg.start) state_d = CHECK;
            CHECK:   state_d = (rem_q == '0) ? IDLE : AR_REQ;
            AR_REQ:  if (ar_hs) state_d = AW_REQ;
            AW_REQ:  if (aw_hs) state_d = STREAM;
            STREAM:  if (w_hs && wlast_o) state_d = RESP;
            RESP:    if (b_hs) state_d = CHECK;
            default: state_d = IDLE;
        endcase
    end

    // remaining words, beat counter, read-side completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem_q     <= '0;
            wcnt_q    <= '0;
            rd_done_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            if (state_q == IDLE && cfg.start)
                rem_q <= cfg.qty;
            else if (b_hs)
                rem_q <= rem_q - beats_q;

            if (state_q == CHECK)
                wcnt_q <= '0;
            else if (w_hs)
                wcnt_q <= wcnt_q + 1'b1;

            if (ar_hs)
                rd_done_q <= 1'b0;
            else if (r_hs && rlast_i)
                rd_done_q <= 1'b1;

            done_q <= (state_q == CHECK) && (rem_q == '0);
        end
    end

    // addresses and burst size
    always_ff @(posedge clk) begin
        if (state_q == IDLE && cfg.start) begin
            src_q <= cfg.src_addr;
            dst_q <= cfg.dst_addr;
        end else if (b_hs) begin
            src_q <= src_q + step;
            dst_q <= dst_q + step;
        end
        if (state_q == CHECK)
            beats_q <= (rem_q < MAX_BEATS) ? rem_q : MAX_BEATS;
    end

    assign araddr_o  = src_q;
    assign arlen_o   = len;
    assign arvalid_o = (state_q == AR_REQ);
    assign awaddr_o  = dst_q;
    assign awlen_o   = len;
    assign awvalid_o = (state_q == AW_REQ);

    // reads stall while the buffer is full
    assign rready_o  = (state_q == STREAM) && !fifo_full && !rd_done_q;
    assign wvalid_o  = (state_q == STREAM) && !fifo_empty;
    assign wlast_o   = (wcnt_q == len) && !fifo_empty;
    assign bready_o  = (state_q == RESP);

    assign busy_o     = (state_q != IDLE);
    assign done_o     = done_q;
    assign bad_resp_o = b_hs && (axi_resp_e'(bresp_i) != OKAY);

    dma_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wen_i   (r_hs),
        .ren_i   (w_hs),
        .data_i  (rdata_i),
        .data_o  (wdata_o),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid_o && !arready_i |=> arvalid_o);

    a_awvalid_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid_o && !awready_i |=> awvalid_o);

    a_wlast_with_wvalid: assert property (@(posedge clk) disable iff (rst)
        wlast_o |-> wvalid_o);

endmodule

// ==== logic/dma_status.sv ====
`timescale 1ns/1ps

module dma_status (
    input  logic clk,
    input  logic rst,
    input  logic done_i,
    input  logic bad_resp_i,
    input  logic clr_i,
    output logic irq_o,
    output logic err_o
);
    // a set in the same cycle as a clear keeps the flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            if (done_i)
                irq_o <= 1'b1;
            else if (clr_i)
                irq_o <= 1'b0;

            if (bad_resp_i)
                err_o <= 1'b1;
            else if (clr_i)
                err_o <= 1'b0;
        end
    end

endmodule

// ==== logic/dma_top.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      reg_we_i,
    input  logic [3:0]                reg_addr_i,
    input  logic [`DMA_DATA_BITS-1:0] reg_wdata_i,
    output logic [`DMA_ADDR_BITS-1:0] araddr_o,
    output logic [`DMA_LEN_BITS-1:0]  arlen_o,
    output logic                      arvalid_o,
    input  logic                      arready_i,
    input  logic [`DMA_DATA_BITS-1:0] rdata_i,
    input  logic                      rlast_i,
    input  logic                      rvalid_i,
    output logic                      rready_o,
    output logic [`DMA_ADDR_BITS-1:0] awaddr_o,
    output logic [`DMA_LEN_BITS-1:0]  awlen_o,
    output logic                      awvalid_o,
    input  logic                      awready_i,
    output logic [`DMA_DATA_BITS-1:0] wdata_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  logic                      wready_i,
    input  logic [1:0]                bresp_i,
    input  logic                      bvalid_i,
    output logic                      bready_o,
    output logic                      busy_o,
    output logic                      irq_o,
    output logic                      err_o
);
    logic clr;
    logic done;
    logic bad_resp;

    dma_cfg_if u_cfg ();

    dma_reg_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .cfg         (u_cfg),
        .clr_o       (clr)
    );

    dma_burst_engine u_engine (
        .clk        (clk),
        .rst        (rst),
        .cfg        (u_cfg),
        .busy_o     (busy_o),
        .done_o     (done),
        .bad_resp_o (bad_resp),
        .araddr_o   (araddr_o),
        .arlen_o    (arlen_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rlast_i    (rlast_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o),
        .awaddr_o   (awaddr_o),
        .awlen_o    (awlen_o),
        .awvalid_o  (awvalid_o),
        .awready_i  (awready_i),
        .wdata_o    (wdata_o),
        .wlast_o    (wlast_o),
        .wvalid_o   (wvalid_o),
        .wready_i   (wready_i),
        .bresp_i    (bresp_i),
        .bvalid_i   (bvalid_i),
        .bready_o   (bready_o)
    );

    dma_status u_status (
        .clk        (clk),
        .rst        (rst),
        .done_i     (done),
        .bad_resp_i (bad_resp),
        .clr_i      (clr),
        .irq_o      (irq_o),
        .err_o      (err_o)
    );

endmodule

// ==== testbench/dma_checker.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      new_row_i,
    input  logic [`DMA_ADDR_BITS-1:0] exp_src_i,
    input  logic [`DMA_ADDR_BITS-1:0] exp_dst_i,
    input  logic [`DMA_QTY_BITS-1:0]  exp_qty_i,
    input  logic                      exp_err_i,
    input  logic [`DMA_ADDR_BITS-1:0] araddr_i,
    input  logic [`DMA_LEN_BITS-1:0]  arlen_i,
    input  logic                      arvalid_i,
    input  logic                      arready_i,
    input  logic                      rvalid_i,
    input  logic                      rready_i,
    input  logic [`DMA_ADDR_BITS-1:0] awaddr_i,
    input  logic [`DMA_LEN_BITS-1:0]  awlen_i,
    input  logic                      awvalid_i,
    input  logic                      awready_i,
    input  logic [`DMA_DATA_BITS-1:0] wdata_i,
    input  logic                      wlast_i,
    input  logic                      wvalid_i,
    input  logic                      wready_i,
    input  logic                      bvalid_i,
    input  logic                      bready_i,
    input  logic                      busy_i,
    input  logic                      irq_i,
    input  logic                      err_i,
    output int                        errors_o
);
    int   ar_words;
    int   aw_words;
    int   r_words;
    int   w_words;
    int   w_beat;
    int   aw_len;
    logic irq_prev;
    logic b_owed;
    logic started;

    initial begin
        errors_o = 0;
        irq_prev = 1'b0;
    end

    // source memory holds the word address xor a fixed tag
    function automatic logic [31:0] source_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    // expected length field for a burst starting after done_words
    function automatic int burst_len(input int done_words);
        int left;
        left = int'(exp_qty_i) - done_words;
        return ((left < `DMA_MAX_BEATS) ? left : `DMA_MAX_BEATS) - 1;
    endfunction

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors_o++;
            $display("FAILED %s: expected 0x%08h, got 0x%08h", name, exp, got);
        end
    endtask

    task automatic report_problem(input string msg);
        errors_o++;
        $display("%s at %0t", msg, $time);
    endtask

    always @(posedge clk) begin
        if (rst || new_row_i) begin
            if (rst && (arvalid_i || awvalid_i || wvalid_i || rready_i || bready_i
                        || busy_i || irq_i || err_i))
                report_problem("a valid, ready or status output was high during reset");
            ar_words = 0;
            aw_words = 0;
            r_words  = 0;
            w_words  = 0;
            w_beat   = 0;
            aw_len   = 0;
            b_owed   = 1'b0;
            started  = 1'b0;
        end else begin
            // status stays clear until this transfer starts
            if (!started && (irq_i || err_i))
                report_problem("irq_o or err_o set before the transfer started");
            if (busy_i)
                started = 1'b1;
            if (rready_i && (r_words - w_words) >= `DMA_FIFO_DEPTH)
                report_problem("rready_o high while the buffer was full");
            if (bready_i && !b_owed)
                report_problem("bready_o high with no write burst waiting for a response");
            if (bvalid_i && bready_i)
                b_owed = 1'b0;
            if (arvalid_i && ar_words >= int'(exp_qty_i))
                report_problem("arvalid_o raised after every word was already requested");
            if (arvalid_i && arready_i) begin
                compare_hex("araddr_o", araddr_i, exp_src_i + 32'(4 * ar_words));
                compare_hex("arlen_o", 32'(arlen_i), 32'(burst_len(ar_words)));
                ar_words += int'(arlen_i) + 1;
            end
            if (awvalid_i && aw_words >= int'(exp_qty_i))
                report_problem("awvalid_o raised after every word was already written");
            if (awvalid_i && awready_i) begin
                aw_len = burst_len(aw_words);
                compare_hex("awaddr_o", awaddr_i, exp_dst_i + 32'(4 * aw_words));
                compare_hex("awlen_o", 32'(awlen_i), 32'(aw_len));
                aw_words += int'(awlen_i) + 1;
            end
            // the buffer can only hand out words that were already read
            if (wvalid_i && w_words >= r_words)
                report_problem("wvalid_o high before the matching read data arrived");
            if (wvalid_i && wready_i) begin
                compare_hex("wdata_o", wdata_i, source_word(exp_src_i + 32'(4 * w_words)));
                compare_hex("wlast_o", 32'(wlast_i), 32'(w_beat == aw_len));
                if (wlast_i)
                    b_owed = 1'b1;
                w_words++;
                w_beat = (w_beat == aw_len) ? 0 : w_beat + 1;
            end
            if (rvalid_i && rready_i)
                r_words++;
            if (busy_i && irq_i)
                report_problem("irq_o set while the engine was still busy");
            if (busy_i && err_i && !exp_err_i)
                report_problem("err_o set during a transfer that expects only OKAY");
            // end of transfer
            if (irq_i && !irq_prev) begin
                compare_hex("busy_o", 32'(busy_i), 32'h0);
                compare_hex("err_o", 32'(err_i), 32'(exp_err_i));
                compare_hex("read beat count", 32'(r_words), 32'(exp_qty_i));
                compare_hex("write beat count", 32'(w_words), 32'(exp_qty_i));
                compare_hex("araddr_o word count", 32'(ar_words), 32'(exp_qty_i));
                compare_hex("awaddr_o word count", 32'(aw_words), 32'(exp_qty_i));
            end
        end
        irq_prev = irq_i;
    end

endmodule

// ==== testbench/dma_tb.sv ====
`timescale 1ns/1ps
`include "dma_defs.svh"

module dma_tb import dma_pkg::*;;
    localparam int NUM_ROWS    = 7;
    localparam int IRQ_TIMEOUT = 5000;
    localparam int CLR_TIMEOUT = 20;

    typedef struct packed {
        logic [31:0] src;
        logic [31:0] dst;
        logic [15:0] qty;
        logic        throttle;
        logic        exp_err;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic                      reg_we_i;
    logic [3:0]                reg_addr_i;
    logic [`DMA_DATA_BITS-1:0] reg_wdata_i;
    logic [`DMA_ADDR_BITS-1:0] araddr_o;
    logic [`DMA_LEN_BITS-1:0]  arlen_o;
    logic                      arvalid_o;
    logic                      arready_i;
    logic [`DMA_DATA_BITS-1:0] rdata_i;
    logic                      rlast_i;
    logic                      rvalid_i;
    logic                      rready_o;
    logic [`DMA_ADDR_BITS-1:0] awaddr_o;
    logic [`DMA_LEN_BITS-1:0]  awlen_o;
    logic                      awvalid_o;
    logic                      awready_i;
    logic [`DMA_DATA_BITS-1:0] wdata_o;
    logic                      wlast_o;
    logic                      wvalid_o;
    logic                      wready_i;
    logic [1:0]                bresp_i;
    logic                      bvalid_i;
    logic                      bready_o;
    logic                      busy_o;
    logic                      irq_o;
    logic                      err_o;

    row_t        rows [NUM_ROWS];
    row_t        cur;
    logic        new_row;
    logic        throttle;
    logic [31:0] lfsr_q;
    int          tb_errors;
    int          chk_errors;

    dma_top u_dma_top (.*);

    dma_checker u_checker (
        .clk       (clk),
        .rst       (rst),
        .new_row_i (new_row),
        .exp_src_i (cur.src),
        .exp_dst_i (cur.dst),
        .exp_qty_i (cur.qty),
        .exp_err_i (cur.exp_err),
        .araddr_i  (araddr_o),
        .arlen_i   (arlen_o),
        .arvalid_i (arvalid_o),
        .arready_i (arready_i),
        .rvalid_i  (rvalid_i),
        .rready_i  (rready_o),
        .awaddr_i  (awaddr_o),
        .awlen_i   (awlen_o),
        .awvalid_i (awvalid_o),
        .awready_i (awready_i),
        .wdata_i   (wdata_o),
        .wlast_i   (wlast_o),
        .wvalid_i  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_i  (bready_o),
        .busy_i    (busy_o),
        .irq_i     (irq_o),
        .err_i     (err_o),
        .errors_o  (chk_errors)
    );

    // taps x^32 + x^22 + x^2 + x + 1 with the new bit entering at bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] read_pattern(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // AXI slave memory with one read and one write burst at a time
    initial begin : memory_model
        logic        rd_active;
        logic [31:0] rd_addr;
        int          rd_left;
        logic        wr_active;
        logic        wr_bad;
        logic        b_pend;
        logic [2:0]  gate;
        rd_active = 1'b0;
        rd_addr   = '0;
        rd_left   = 0;
        wr_active = 1'b0;
        wr_bad    = 1'b0;
        b_pend    = 1'b0;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        rlast_i   = 1'b0;
        rdata_i   = '0;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        bresp_i   = OKAY;
        forever begin
            @(posedge clk);
            if (arvalid_o && arready_i) begin
                rd_active = 1'b1;
                rd_addr   = araddr_o;
                rd_left   = int'(arlen_o) + 1;
            end
            if (rvalid_i && rready_o) begin
                rd_addr   = rd_addr + 32'd4;
                rd_left   = rd_left - 1;
                rd_active = (rd_left != 0);
            end
            if (awvalid_o && awready_i) begin
                wr_active = 1'b1;
                wr_bad    = (awaddr_o[31:28] == 4'hF);
            end
            if (wvalid_o && wready_i && wlast_o) begin
                wr_active = 1'b0;
                b_pend    = 1'b1;
            end
            if (bvalid_i && bready_o)
                b_pend = 1'b0;
            @(negedge clk);
            // one LFSR step per gated ready bit
            gate = 3'b111;
            if (throttle) begin
                for (int b = 0; b < 3; b++) begin
                    lfsr_q  = lfsr_next(lfsr_q);
                    gate[b] = lfsr_q[0];
                end
            end
            arready_i = !rd_active && gate[0];
            rvalid_i  = rd_active;
            rlast_i   = rd_active && (rd_left == 1);
            rdata_i   = read_pattern(rd_addr);
            awready_i = !wr_active && !b_pend && gate[1];
            wready_i  = wr_active && gate[2];
            bvalid_i  = b_pend;
            bresp_i   = wr_bad ? SLVERR : OKAY;
        end
    end

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk);
        reg_we_i    = 1'b0;
    endtask

    task automatic run_row(input int n, output logic ok);
        int cyc;
        ok       = 1'b1;
        cur      = rows[n];
        throttle = rows[n].throttle;
        new_row  = 1'b1;
        @(negedge clk);
        new_row  = 1'b0;
        write_reg(`DMA_REG_SRC, cur.src);
        write_reg(`DMA_REG_DST, cur.dst);
        write_reg(`DMA_REG_QTY, {16'h0, cur.qty});
        write_reg(`DMA_REG_CTRL, 32'h1);
        cyc = 0;
        while (!irq_o && cyc < IRQ_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!irq_o) begin
            $display("timeout waiting for irq_o on row %0d", n);
            tb_errors++;
            ok = 1'b0;
        end else begin
            // clear both status flags
            write_reg(`DMA_REG_CTRL, 32'h2);
            cyc = 0;
            while ((irq_o || err_o) && cyc < CLR_TIMEOUT) begin
                @(negedge clk);
                cyc++;
            end
            if (irq_o || err_o) begin
                $display("irq_o or err_o did not clear on row %0d", n);
                tb_errors++;
                ok = 1'b0;
            end
        end
    endtask

    task automatic finish_run();
        $display("error count: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    endtask

    initial begin : main_seq
        logic ok;
        rst         = 1'b1;
        reg_we_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        new_row     = 1'b0;
        throttle    = 1'b0;
        cur         = '0;
        tb_errors   = 0;
        lfsr_q      = 32'he631_5c53;
        // src, dst, qty, throttle, expect error
        rows[0] = {32'h0000_1000, 32'h0002_0000, 16'd1, 1'b0, 1'b0};
        rows[1] = {32'h0000_2000, 32'h0002_1000, 16'd16, 1'b0, 1'b0};
        rows[2] = {32'h0000_3004, 32'h0002_2008, 16'd17, 1'b1, 1'b0};
        rows[3] = {32'h0000_4000, 32'h0002_3000, 16'd40, 1'b1, 1'b0};
        rows[4] = {32'h0000_5000, 32'h0002_4000, 16'd0, 1'b0, 1'b0};
        rows[5] = {32'h0000_6000, 32'hF000_0000, 16'd5, 1'b1, 1'b1};
        rows[6] = {32'h0000_7000, 32'h0002_5000, 16'd20, 1'b1, 1'b0};
        repeat (10) @(negedge clk);
        rst = 1'b0;
        ok  = 1'b1;
        for (int n = 0; n < NUM_ROWS && ok; n++)
            run_row(n, ok);
        // let the checker see the last edge
        @(negedge clk);
        finish_run();
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/dma_pkg.sv
logic/dma_cfg_if.sv
logic/dma_reg_decode.sv
logic/dma_fifo.sv
logic/dma_burst_engine.sv
logic/dma_status.sv
logic/dma_top.sv
testbench/dma_checker.sv
testbench/dma_tb.sv

// ==== Bender.yml ====
package:
  name: dma

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dma_pkg.sv
      - logic/dma_cfg_if.sv
      - logic/dma_reg_decode.sv
      - logic/dma_fifo.sv
      - logic/dma_burst_engine.sv
      - logic/dma_status.sv
      - logic/dma_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/dma_checker.sv
      - testbench/dma_tb.sv
